/* compile.f */
verilog/lsu_pkg.sv
verilog/dmem_if.sv
verilog/prio_select.sv
verilog/load_buffer.sv
verilog/dmem_model.sv
verilog/cdb_arbiter.sv
verilog/lsu_csr.sv
verilog/load_unit_top.sv
dv/load_unit_asserts.sv
dv/load_unit_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f compile.f --top-module load_unit_tb --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vload_unit_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

/* dv/load_unit_tb.sv */
`timescale 1ns/1ps

module load_unit_tb;
    import lsu_pkg::*;

    localparam int NUM_ROWS        = 12;
    localparam int NUM_PASSES      = 3;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 64 * (NUM_PASSES + 2);
    localparam logic [1:0] SB_EMPTY    = 2'd0;
    localparam logic [1:0] SB_EXPECT   = 2'd1;
    localparam logic [1:0] SB_SQUASHED = 2'd2;

    typedef struct {
        addr_t     base;
        addr_t     offset;
        mem_size_e size;
        tag_t      tag;
        bmask_t    bmask;
        logic      squash;
    } load_row_t;

    logic      clock;
    logic      reset;
    logic      issue_valid;
    addr_t     issue_base;
    addr_t     issue_offset;
    mem_size_e issue_size;
    tag_t      issue_tag;
    bmask_t    issue_bmask;
    logic      full;
    br_task_e  br_task;
    bmask_t    br_id;
    logic      cdb_valid;
    tag_t      cdb_tag;
    data_t     cdb_data;
    logic      cdb_ready;
    logic      psel;
    logic      penable;
    logic      pwrite;
    addr_t     paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pready;
    logic      pslverr;

    load_row_t   rows [NUM_ROWS];
    logic [1:0]  sb_state [64];
    data_t       sb_data [64];
    lat_t        pass_latency [NUM_PASSES] = '{4'd3, 4'd1, 4'd9};
    int          outstanding;
    int          broadcast_count;
    logic        random_ready;
    word_t       rdata;
    logic        rerr;

    load_unit_top #(.DEPTH(4)) dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic step();
        @(posedge clock);
        #2;
        if (random_ready) begin
            cdb_ready = 1'($urandom_range(0, 1));
        end
    endtask

    // Memory byte at a is a[7:0] ^ 0xA5, zero-extended little endian
    function automatic data_t expect_load(addr_t addr, mem_size_e size);
        data_t value;
        addr_t byte_addr;
        int    nbytes;
        case (size)
            BYTE:    nbytes = 1;
            HALF:    nbytes = 2;
            WORD:    nbytes = 4;
            default: nbytes = 8;
        endcase
        value = '0;
        for (int k = 0; k < nbytes; k++) begin
            byte_addr = addr + addr_t'(k);
            value[8*k +: 8] = byte_addr[7:0] ^ 8'hA5;
        end
        return value;
    endfunction

    task automatic apb_read(input addr_t addr, output word_t data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        step();
        penable = 1'b1;
        @(negedge clock);
        check_value("pready", 64'(pready), 64'd1);
        data = prdata;
        err  = pslverr;
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input word_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        step();
        penable = 1'b1;
        @(negedge clock);
        check_value("pslverr", 64'(pslverr), 64'd0);
        step();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_register(input string name, input addr_t addr, input word_t expected);
        word_t data;
        logic  err;
        apb_read(addr, data, err);
        check_value(name, 64'(data), 64'(expected));
        check_value("pslverr", 64'(err), 64'd0);
    endtask

    // Shifted rows move to the other half of the block, alignment kept
    task automatic issue_load(input int r, input logic shifted);
        addr_t offset;
        addr_t addr;
        offset = rows[r].offset;
        if (shifted) begin
            offset = offset + ((rows[r].size == DOUBLE) ? addr_t'(8) : addr_t'(4));
        end
        addr = rows[r].base + offset;
        sb_data[rows[r].tag] = expect_load(addr, rows[r].size);
        if (rows[r].squash) begin
            sb_state[rows[r].tag] = SB_SQUASHED;
        end else begin
            sb_state[rows[r].tag] = SB_EXPECT;
            outstanding++;
        end
        issue_valid  = 1'b1;
        issue_base   = rows[r].base;
        issue_offset = offset;
        issue_size   = rows[r].size;
        issue_tag    = rows[r].tag;
        issue_bmask  = rows[r].bmask;
        @(negedge clock);
        while (full) begin
            step();
            @(negedge clock);
        end
        step();
        issue_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            step();
        end
    endtask

    task automatic branch_event(input br_task_e kind, input bmask_t id);
        br_task = kind;
        br_id   = id;
        step();
        br_task = NONE;
        br_id   = '0;
    endtask

    task automatic run_pass(input int pass, input lat_t lat);
        apb_write(CSR_LATENCY, word_t'(lat));
        read_register("LATENCY", CSR_LATENCY, word_t'(lat));
        for (int r = 0; r < 8; r++) begin
            issue_load(r, pass % 2 == 1);
        end
        wait_drain();
        // Loads held back by a cleared enable
        apb_write(CSR_CTRL, 32'd0);
        for (int r = 8; r < NUM_ROWS; r++) begin
            issue_load(r, pass % 2 == 1);
        end
        repeat (20) begin
            @(negedge clock);
            check_value("cdb_valid", 64'(cdb_valid), 64'd0);
            check_value("full", 64'(full), 64'd1);
        end
        step();
        branch_event(SQUASH, 4'b0001);
        check_value("full", 64'(full), 64'd0);
        branch_event(CLEAR, 4'b0010);
        // Cleared bit no longer matches anything
        branch_event(SQUASH, 4'b0010);
        apb_write(CSR_CTRL, 32'd1);
        wait_drain();
        read_register("DONE_COUNT", CSR_DONE, word_t'(broadcast_count));
    endtask

    task automatic run_backpressure();
        cdb_ready = 1'b0;
        for (int r = 0; r < 4; r++) begin
            issue_load(r, 1'b0);
        end
        do @(negedge clock); while (!cdb_valid);
        repeat (8) begin
            @(negedge clock);
            check_value("full", 64'(full), 64'd1);
            check_value("cdb_valid", 64'(cdb_valid), 64'd1);
            check_value("cdb_tag", 64'(cdb_tag), 64'(rows[0].tag));
        end
        step();
        random_ready = 1'b1;
        for (int r = 4; r < 8; r++) begin
            issue_load(r, 1'b1);
        end
        wait_drain();
        random_ready = 1'b0;
        cdb_ready    = 1'b1;
        read_register("DONE_COUNT", CSR_DONE, word_t'(broadcast_count));
    endtask

    // Scoreboard update on every accepted broadcast
    always @(negedge clock) begin
        if (!reset && cdb_valid && cdb_ready) begin
            if (sb_state[cdb_tag] != SB_EXPECT) begin
                fail_run($sformatf("A broadcast carried tag %h, which was not expected",
                                   cdb_tag));
            end
            check_value("cdb_data", cdb_data, sb_data[cdb_tag]);
            sb_state[cdb_tag] = SB_EMPTY;
            outstanding--;
            broadcast_count++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        fail_run($sformatf("Timeout: the test did not finish in %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        void'($urandom(32'hfd1f2bd3));
        reset           = 1'b1;
        issue_valid     = 1'b0;
        issue_base      = '0;
        issue_offset    = '0;
        issue_size      = BYTE;
        issue_tag       = '0;
        issue_bmask     = '0;
        br_task         = NONE;
        br_id           = '0;
        cdb_ready       = 1'b1;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        random_ready    = 1'b0;
        outstanding     = 0;
        broadcast_count = 0;
        for (int t = 0; t < 64; t++) begin
            sb_state[t] = SB_EMPTY;
            sb_data[t]  = '0;
        end
        // base, offset, size, tag, branch mask, squashed
        rows[0]  = '{32'h1000, 32'h00, BYTE,   6'd1,  4'b0000, 1'b0};
        rows[1]  = '{32'h1000, 32'h11, BYTE,   6'd2,  4'b0000, 1'b0};
        rows[2]  = '{32'h2040, 32'h02, BYTE,   6'd3,  4'b0000, 1'b0};
        rows[3]  = '{32'h20f0, 32'h03, BYTE,   6'd4,  4'b0000, 1'b0};
        rows[4]  = '{32'h3000, 32'h20, HALF,   6'd5,  4'b0000, 1'b0};
        rows[5]  = '{32'h3008, 32'h1a, HALF,   6'd6,  4'b0000, 1'b0};
        rows[6]  = '{32'h4000, 32'h30, WORD,   6'd7,  4'b0000, 1'b0};
        rows[7]  = '{32'h5000, 32'h48, DOUBLE, 6'd8,  4'b0000, 1'b0};
        rows[8]  = '{32'h6000, 32'h01, BYTE,   6'd9,  4'b0001, 1'b1};
        rows[9]  = '{32'h6010, 32'h04, WORD,   6'd10, 4'b0010, 1'b0};
        rows[10] = '{32'h6020, 32'h06, HALF,   6'd11, 4'b0011, 1'b1};
        rows[11] = '{32'h6038, 32'h00, DOUBLE, 6'd12, 4'b0100, 1'b0};

        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;
        step();
        check_value("full", 64'(full), 64'd0);
        check_value("cdb_valid", 64'(cdb_valid), 64'd0);
        check_value("pslverr", 64'(pslverr), 64'd0);
        read_register("CTRL", CSR_CTRL, 32'd1);
        read_register("LATENCY", CSR_LATENCY, 32'd3);
        read_register("DONE_COUNT", CSR_DONE, 32'd0);
        apb_read(32'hc, rdata, rerr);
        check_value("pslverr", 64'(rerr), 64'd1);

        for (int p = 0; p < NUM_PASSES; p++) begin
            run_pass(p, pass_latency[p]);
        end
        run_backpressure();

        $display("Testbench passed");
        $finish;
    end

endmodule

/* dv/load_unit_asserts.sv */
`timescale 1ns/1ps

module load_unit_asserts (
    input logic           clock,
    input logic           reset,
    input logic           cdb_valid,
    input logic           cdb_ready,
    input lsu_pkg::tag_t  cdb_tag,
    input lsu_pkg::data_t cdb_data,
    input logic           req,
    input logic           busy,
    input logic           resp_valid
);

    // Result bus payload holds until taken
    cdb_hold: assert property (@(posedge clock) disable iff (reset)
        cdb_valid && !cdb_ready |=> cdb_valid && $stable(cdb_tag) && $stable(cdb_data))
        else $error("result bus changed while waiting for cdb_ready");

    // Memory goes busy right after taking a request
    req_taken: assert property (@(posedge clock) disable iff (reset) req |=> busy)
        else $error("memory request was not taken");

    resp_pulse: assert property (@(posedge clock) disable iff (reset)
        resp_valid |=> !resp_valid)
        else $error("memory response lasted longer than one cycle");

endmodule

// Each instance watches only its own side
bind cdb_arbiter load_unit_asserts cdb_checks (
    .clock     (clock),
    .reset     (reset),
    .cdb_valid (cdb_valid),
    .cdb_ready (cdb_ready),
    .cdb_tag   (cdb_tag),
    .cdb_data  (cdb_data),
    .req       (1'b0),
    .busy      (1'b0),
    .resp_valid(1'b0)
);

bind load_buffer load_unit_asserts buffer_checks (
    .clock     (clock),
    .reset     (reset),
    .cdb_valid (1'b0),
    .cdb_ready (1'b1),
    .cdb_tag   ('0),
    .cdb_data  ('0),
    .req       (mem.req),
    .busy      (mem.busy),
    .resp_valid(mem.resp_valid)
);

/* verilog/load_unit_top.sv */
`timescale 1ns/1ps

module load_unit_top #(
    parameter int DEPTH = 4
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               issue_valid,
    input  lsu_pkg::addr_t     issue_base,
    input  lsu_pkg::addr_t     issue_offset,
    input  lsu_pkg::mem_size_e issue_size,
    input  lsu_pkg::tag_t      issue_tag,
    input  lsu_pkg::bmask_t    issue_bmask,
    output logic               full,
    input  lsu_pkg::br_task_e  br_task,
    input  lsu_pkg::bmask_t    br_id,
    output logic               cdb_valid,
    output lsu_pkg::tag_t      cdb_tag,
    output lsu_pkg::data_t     cdb_data,
    input  logic               cdb_ready,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  lsu_pkg::addr_t     paddr,
    input  lsu_pkg::word_t     pwdata,
    output lsu_pkg::word_t     prdata,
    output logic               pready,
    output logic               pslverr
);
    import lsu_pkg::*;

    ld_entry_t [DEPTH-1:0] entries;
    logic [DEPTH-1:0]      ready;
    logic [DEPTH-1:0]      release_vec;
    logic                  done;
    logic                  enable;
    lat_t                  latency;

    dmem_if #(.DEPTH(DEPTH)) mem_bus ();

    load_buffer #(
        .DEPTH(DEPTH)
    ) buffer0 (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_base  (issue_base),
        .issue_offset(issue_offset),
        .issue_size  (issue_size),
        .issue_tag   (issue_tag),
        .issue_bmask (issue_bmask),
        .full        (full),
        .br_task     (br_task),
        .br_id       (br_id),
        .enable      (enable),
        .mem         (mem_bus.buffer),
        .entries     (entries),
        .ready       (ready),
        .release_vec (release_vec)
    );

    dmem_model mem0 (
        .clock  (clock),
        .reset  (reset),
        .mem    (mem_bus.memory),
        .latency(latency)
    );

    cdb_arbiter #(
        .DEPTH(DEPTH)
    ) arb0 (
        .clock      (clock),
        .reset      (reset),
        .ready      (ready),
        .entries    (entries),
        .cdb_ready  (cdb_ready),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_data   (cdb_data),
        .release_vec(release_vec),
        .done       (done)
    );

    lsu_csr csr0 (
        .clock  (clock),
        .reset  (reset),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr),
        .done   (done),
        .enable (enable),
        .latency(latency)
    );

endmodule

/* verilog/lsu_csr.sv */
`timescale 1ns/1ps

module lsu_csr (
    input  logic           clock,
    input  logic           reset,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  lsu_pkg::addr_t paddr,
    input  lsu_pkg::word_t pwdata,
    output lsu_pkg::word_t prdata,
    output logic           pready,
    output logic           pslverr,
    input  logic           done,
    output logic           enable,
    output lsu_pkg::lat_t  latency
);
    import lsu_pkg::*;

    word_t done_count;
    logic  access;
    logic  mapped;

    // Access phase of a transfer
    assign access = psel && penable;
    assign mapped = paddr == CSR_CTRL || paddr == CSR_LATENCY || paddr == CSR_DONE;

    always_ff @(posedge clock) begin
        if (reset) begin
            enable     <= 1'b1;
            latency    <= LAT_RESET;
            done_count <= '0;
        end else begin
            if (access && pwrite) begin
                case (paddr)
                    CSR_CTRL:    enable  <= pwdata[0];
                    CSR_LATENCY: latency <= pwdata[3:0];
                    default: ;
                endcase
            end
            if (done) begin
                done_count <= done_count + word_t'(1);
            end
        end
    end

    always_comb begin
        case (paddr)
            CSR_CTRL:    prdata = {31'b0, enable};
            CSR_LATENCY: prdata = {28'b0, latency};
            CSR_DONE:    prdata = done_count;
            default:     prdata = '0;
        endcase
    end

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

endmodule

/* verilog/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int DEPTH = 4
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [DEPTH-1:0]               ready,
    input  lsu_pkg::ld_entry_t [DEPTH-1:0] entries,
    input  logic                           cdb_ready,
    output logic                           cdb_valid,
    output lsu_pkg::tag_t                  cdb_tag,
    output lsu_pkg::data_t                 cdb_data,
    output logic [DEPTH-1:0]               release_vec,
    output logic                           done
);

    logic [DEPTH-1:0] fresh_gnt;
    logic [DEPTH-1:0] held_gnt;
    logic [DEPTH-1:0] sel;
    logic             holding;

    prio_select #(
        .WIDTH(DEPTH)
    ) picker (
        .req(ready),
        .gnt(fresh_gnt)
    );

    // A stalled load keeps the bus even if a lower slot finishes
    assign sel         = (holding && (held_gnt & ready) != '0) ? held_gnt : fresh_gnt;
    assign cdb_valid   = sel != '0;
    assign release_vec = cdb_ready ? sel : '0;
    assign done        = cdb_valid && cdb_ready;

    always_comb begin
        cdb_tag  = '0;
        cdb_data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (sel[i]) begin
                cdb_tag  = entries[i].tag;
                cdb_data = entries[i].result;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            holding <= 1'b0;
        end else begin
            holding <= cdb_valid && !cdb_ready;
        end
    end

    always_ff @(posedge clock) begin
        held_gnt <= sel;
    end

endmodule

/* verilog/dmem_model.sv */
`timescale 1ns/1ps

module dmem_model (
    input  logic          clock,
    input  logic          reset,
    dmem_if.memory        mem,
    input  lsu_pkg::lat_t latency
);
    import lsu_pkg::*;

    logic busy_q;
    lat_t count;
    lat_t start_count;
    logic take;

    // Each byte is its own address xor 0xA5
    function automatic block_t make_block(addr_t base);
        block_t blk;
        for (int b = 0; b < 8; b++) begin
            blk[b*8 +: 8] = {base[7:3], 3'(b)} ^ 8'hA5;
        end
        return blk;
    endfunction

    // Zero latency behaves as one
    assign start_count = (latency == '0) ? lat_t'(1) : latency;
    assign take        = mem.req && !busy_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q <= 1'b0;
            count  <= '0;
        end else if (take) begin
            busy_q <= 1'b1;
            count  <= start_count;
        end else if (busy_q) begin
            count <= count - lat_t'(1);
            if (count == lat_t'(1)) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            mem.resp_slot <= mem.req_slot;
            mem.resp_data <= make_block(mem.req_addr);
        end
    end

    // Busy stays high through the response cycle
    assign mem.busy       = busy_q;
    assign mem.resp_valid = busy_q && count == lat_t'(1);

endmodule

/* verilog/load_buffer.sv */
`timescale 1ns/1ps

module load_buffer #(
    parameter int DEPTH = 4
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           issue_valid,
    input  lsu_pkg::addr_t                 issue_base,
    input  lsu_pkg::addr_t                 issue_offset,
    input  lsu_pkg::mem_size_e             issue_size,
    input  lsu_pkg::tag_t                  issue_tag,
    input  lsu_pkg::bmask_t                issue_bmask,
    output logic                           full,
    input  lsu_pkg::br_task_e              br_task,
    input  lsu_pkg::bmask_t                br_id,
    input  logic                           enable,
    dmem_if.buffer                         mem,
    output lsu_pkg::ld_entry_t [DEPTH-1:0] entries,
    output logic [DEPTH-1:0]               ready,
    input  logic [DEPTH-1:0]               release_vec
);
    import lsu_pkg::*;

    localparam int SLOT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    ld_entry_t [DEPTH-1:0] slots;
    ld_entry_t [DEPTH-1:0] slots_next;
    logic [DEPTH-1:0]      open_slots;
    logic [DEPTH-1:0]      pending;
    logic [DEPTH-1:0]      kill;
    logic [DEPTH-1:0]      freed;
    logic [DEPTH-1:0]      alloc_gnt;
    logic [DEPTH-1:0]      issue_gnt;
    logic                  accept;
    logic                  issue_fire;
    addr_t                 target_addr;

    function automatic data_t extract_lane(block_t blk, logic [2:0] offset, mem_size_e size);
        data_t lane;
        case (size)
            BYTE:    lane = {56'b0, blk[{offset, 3'b000} +: 8]};
            HALF:    lane = {48'b0, blk[{offset[2:1], 4'b0000} +: 16]};
            WORD:    lane = {32'b0, blk[{offset[2], 5'b00000} +: 32]};
            default: lane = blk;
        endcase
        return lane;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            open_slots[i] = slots[i].state == IDLE;
            kill[i] = br_task == SQUASH && slots[i].state != IDLE
                      && (slots[i].bmask & br_id) != '0;
            // Squashed slots neither issue nor broadcast
            pending[i] = slots[i].state == READY_TO_ISSUE && !kill[i];
            ready[i]   = slots[i].state == DATA_READY && !kill[i];
        end
    end

    assign freed       = kill | release_vec;
    assign full        = (open_slots | freed) == '0;
    assign accept      = issue_valid && !full;
    assign target_addr = issue_base + issue_offset;
    assign issue_fire  = enable && !mem.busy && pending != '0;
    assign entries     = slots;

    prio_select #(
        .WIDTH(DEPTH)
    ) allocator (
        .req(open_slots | freed),
        .gnt(alloc_gnt)
    );

    prio_select #(
        .WIDTH(DEPTH)
    ) issuer (
        .req(pending),
        .gnt(issue_gnt)
    );

    always_comb begin
        mem.req      = issue_fire;
        mem.req_addr = '0;
        mem.req_slot = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (issue_gnt[i]) begin
                mem.req_addr = {slots[i].addr[31:3], 3'b000};
                mem.req_slot = SLOT_W'(i);
            end
        end
    end

    always_comb begin
        slots_next = slots;
        for (int i = 0; i < DEPTH; i++) begin
            // Branch resolution first
            if (kill[i]) begin
                slots_next[i] = '0;
            end else if (br_task == CLEAR) begin
                slots_next[i].bmask = slots[i].bmask & ~br_id;
            end

            if (release_vec[i]) begin
                slots_next[i] = '0;
            end

            // Stale responses for freed slots fall through here
            if (mem.resp_valid && mem.resp_slot == SLOT_W'(i)
                    && slots_next[i].state == WAITING_FOR_DATA) begin
                slots_next[i].result = extract_lane(mem.resp_data, slots_next[i].addr[2:0],
                                                    slots_next[i].size);
                slots_next[i].state  = DATA_READY;
            end

            if (accept && alloc_gnt[i]) begin
                slots_next[i].tag    = issue_tag;
                slots_next[i].bmask  = issue_bmask;
                slots_next[i].size   = issue_size;
                slots_next[i].addr   = target_addr;
                slots_next[i].result = '0;
                slots_next[i].state  = READY_TO_ISSUE;
            end

            if (issue_fire && issue_gnt[i]) begin
                slots_next[i].state = WAITING_FOR_DATA;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                slots[i].state <= IDLE;
            end
        end else begin
            slots <= slots_next;
        end
    end

endmodule

/* verilog/prio_select.sv */
`timescale 1ns/1ps

module prio_select #(
    parameter int WIDTH = 4
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt
);

    // Set where some lower bit already requests
    logic [WIDTH-1:0] lower;

    always_comb begin
        lower = '0;
        for (int i = 1; i < WIDTH; i++) begin
            lower[i] = lower[i-1] | req[i-1];
        end
        gnt = req & ~lower;
    end

endmodule

/* verilog/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if #(
    parameter int DEPTH = 4
);
    import lsu_pkg::*;

    localparam int SLOT_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Request side
    logic              req;
    addr_t             req_addr;
    logic [SLOT_W-1:0] req_slot;

    // Response side
    logic              busy;
    logic              resp_valid;
    logic [SLOT_W-1:0] resp_slot;
    block_t            resp_data;

    modport buffer (
        output req, req_addr, req_slot,
        input  busy, resp_valid, resp_slot, resp_data
    );

    modport memory (
        input  req, req_addr, req_slot,
        output busy, resp_valid, resp_slot, resp_data
    );

endinterface

/* verilog/lsu_pkg.sv */
package lsu_pkg;

    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 64;
    localparam int TAG_W   = 6;
    localparam int BMASK_W = 4;
    localparam int LAT_W   = 4;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [DATA_W-1:0]  data_t;
    // Byte 0 sits in bits 7:0
    typedef logic [63:0]        block_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [BMASK_W-1:0] bmask_t;
    typedef logic [LAT_W-1:0]   lat_t;
    typedef logic [31:0]        word_t;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE
    } mem_size_e;

    typedef enum logic [1:0] {
        NONE,
        SQUASH,
        CLEAR
    } br_task_e;

    typedef enum logic [1:0] {
        IDLE,
        READY_TO_ISSUE,
        WAITING_FOR_DATA,
        DATA_READY
    } ld_state_e;

    typedef struct packed {
        tag_t      tag;
        bmask_t    bmask;
        mem_size_e size;
        addr_t     addr;
        data_t     result;
        ld_state_e state;
    } ld_entry_t;

    // Register block addresses
    localparam addr_t CSR_CTRL    = 32'h0;
    localparam addr_t CSR_LATENCY = 32'h4;
    localparam addr_t CSR_DONE    = 32'h8;
    localparam lat_t  LAT_RESET   = 4'd3;

endpackage
